// File: design/conn_fsm.sv
`timescale 1ns/10ps

module conn_fsm import stream_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     connect,
	input  logic     listen,
	input  rx_evt_t  rx_evt,
	input  logic     ctl_sent,
	input  logic     retry_due,
	output ctl_req_t ctl_req,
	output logic     timer_start,
	output logic     timer_stop,
	output logic     connected
);

	typedef enum logic [2:0] {
		st_closed,
		st_syn_sent,
		st_listening,
		st_synack_sent,
		st_established
	} state_t;

	localparam ctl_req_t REQ_SYN    = '{valid: 1'b1, syn: 1'b1, ack: 1'b0};
	localparam ctl_req_t REQ_SYNACK = '{valid: 1'b1, syn: 1'b1, ack: 1'b1};
	localparam ctl_req_t REQ_ACK    = '{valid: 1'b1, syn: 1'b0, ack: 1'b1};

	state_t state;

	logic got_syn;
	logic got_ack;
	logic got_synack;

	// pure syn or pure ack from the peer
	assign got_syn    = rx_evt.syn_seen && !rx_evt.ack_seen;
	assign got_ack    = rx_evt.ack_seen && !rx_evt.syn_seen;
	assign got_synack = rx_evt.syn_seen && rx_evt.ack_seen;

	//////////////////////////////////////////////////////////////////////
	// handshake state machine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= st_closed;
			ctl_req <= '0;
		end
		else begin
			// request retires once its header hits the wire
			if (ctl_sent) ctl_req.valid <= 1'b0;
			case (state)
				st_closed : begin
					if (connect) begin
						ctl_req <= REQ_SYN;
						state   <= st_syn_sent;
					end
					else if (listen) state <= st_listening;
				end
				st_syn_sent : begin
					// answer with ack and go live right away
					if (got_synack) begin
						ctl_req <= REQ_ACK;
						state   <= st_established;
					end
					else if (retry_due) ctl_req <= REQ_SYN;
				end
				st_listening : begin
					if (got_syn) begin
						ctl_req <= REQ_SYNACK;
						state   <= st_synack_sent;
					end
				end
				st_synack_sent : begin
					if (got_ack) state <= st_established;
					// client retried before our reply landed
					else if (got_syn) ctl_req <= REQ_SYNACK;
				end
				default : ;
			endcase
		end
	end

	// timer runs only while a syn is outstanding
	assign timer_start = ctl_sent && ctl_req.syn && !ctl_req.ack;
	assign timer_stop  = (state != st_syn_sent);
	assign connected   = (state == st_established);

endmodule

// File: design/seg_rx.sv
`timescale 1ns/10ps

module seg_rx import stream_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  phy_t       phy_rx,
	output rx_evt_t    rx_evt,
	output logic [7:0] tcp_dout,
	output logic       tcp_vout
);

	logic [5:0] left;
	logic       is_hdr;
	logic       is_pay;
	seg_hdr_u   hdr;
	rx_evt_t    evt_nxt;
	logic [5:0] left_nxt;

	// any valid byte outside a payload opens a segment
	assign is_hdr = phy_rx.v && (left == '0);
	assign is_pay = phy_rx.v && (left != '0);
	assign hdr    = phy_rx.d;

	//////////////////////////////////////////////////////////////////////
	// header decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		evt_nxt  = '0;
		left_nxt = left;
		if (is_pay) begin
			left_nxt = left - 1'b1;
			// last payload byte closes the segment
			if (left == 6'd1) evt_nxt.seg_done = 1'b1;
		end
		else if (is_hdr) begin
			// kind shares its position in both views
			case (hdr.ctl.kind)
				kind_ctl : begin
					evt_nxt.syn_seen = hdr.ctl.syn;
					evt_nxt.ack_seen = hdr.ctl.ack;
				end
				kind_dat : left_nxt = hdr.dat.amount;
				kind_crd : begin
					evt_nxt.crd_gain   = 1'b1;
					evt_nxt.crd_amount = hdr.dat.amount;
				end
				// unused kind, byte dropped
				default : ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			left     <= '0;
			rx_evt   <= '0;
			tcp_vout <= 1'b0;
		end
		else begin
			left     <= left_nxt;
			rx_evt   <= evt_nxt;
			tcp_vout <= is_pay;
		end
	end

	// data one cycle behind the wire
	always_ff @(posedge clk) begin
		tcp_dout <= phy_rx.d;
	end

endmodule

// File: design/seg_tx.sv
`timescale 1ns/10ps

`include "stream_defines.svh"

module seg_tx import stream_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       connected,
	input  ctl_req_t   ctl_req,
	input  rx_evt_t    rx_evt,
	input  logic [7:0] tcp_din,
	input  logic       tcp_vin,
	output logic       tcp_cts,
	output logic       ctl_sent,
	output phy_t       phy_tx
);

	localparam int MAX_SEG = `STREAM_MAX_SEG;
	localparam int SEG_W   = $clog2(MAX_SEG + 1);
	localparam int IDX_W   = $clog2(MAX_SEG);

	logic [7:0]       buf_mem [MAX_SEG];
	logic [SEG_W-1:0] fill;
	logic [SEG_W-1:0] left;
	logic [IDX_W-1:0] rd_idx;
	logic             dat_busy;
	logic             vin_q;
	logic             conn_q;
	logic [5:0]       credits;
	logic [5:0]       grants;
	logic [7:0]       tx_d;
	logic             tx_v;

	logic     take;
	logic     dat_ready;
	logic     send_ctl;
	logic     send_crd;
	logic     send_dat;
	seg_hdr_u hdr;

	// buffer frozen while its segment drains
	assign tcp_cts = connected && (fill != SEG_W'(MAX_SEG)) && !dat_busy;
	assign take    = tcp_vin && tcp_cts;

	// full buffer, or a pause in the input stream
	assign dat_ready = connected && (fill != '0) && (credits != '0) &&
		((fill == SEG_W'(MAX_SEG)) || !vin_q);

	//////////////////////////////////////////////////////////////////////
	// next segment pick, control then credit then data
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		hdr      = '0;
		send_ctl = 1'b0;
		send_crd = 1'b0;
		send_dat = 1'b0;
		// only between segments
		if (left == '0) begin
			if (ctl_req.valid) begin
				send_ctl     = 1'b1;
				hdr.ctl.kind = kind_ctl;
				hdr.ctl.syn  = ctl_req.syn;
				hdr.ctl.ack  = ctl_req.ack;
			end
			else if (connected && grants != '0) begin
				send_crd       = 1'b1;
				hdr.dat.kind   = kind_crd;
				hdr.dat.amount = grants;
			end
			else if (dat_ready) begin
				// byte taken this cycle rides along
				send_dat       = 1'b1;
				hdr.dat.kind   = kind_dat;
				hdr.dat.amount = 6'(fill + SEG_W'(take));
			end
		end
	end

	assign ctl_sent = send_ctl;

	always_ff @(posedge clk) begin
		if (rst) begin
			fill     <= '0;
			left     <= '0;
			rd_idx   <= '0;
			dat_busy <= 1'b0;
			vin_q    <= 1'b0;
			conn_q   <= 1'b0;
			credits  <= '0;
			grants   <= '0;
			tx_v     <= 1'b0;
		end
		else begin
			vin_q  <= tcp_vin;
			conn_q <= connected;
			// fresh credit pool on connect
			if (connected && !conn_q) credits <= 6'(`STREAM_INIT_CREDITS);
			else credits <= credits - 6'(send_dat) +
				(rx_evt.crd_gain ? rx_evt.crd_amount : 6'd0);
			grants <= (send_crd ? 6'd0 : grants) + 6'(rx_evt.seg_done);
			if (take) fill <= fill + 1'b1;
			if (left != '0) begin
				// payload shift out
				tx_v   <= 1'b1;
				left   <= left - 1'b1;
				rd_idx <= rd_idx + 1'b1;
				if (left == SEG_W'(1)) begin
					dat_busy <= 1'b0;
					fill     <= '0;
				end
			end
			else begin
				tx_v <= send_ctl || send_crd || send_dat;
				if (send_dat) begin
					left     <= fill + SEG_W'(take);
					rd_idx   <= '0;
					dat_busy <= 1'b1;
				end
			end
		end
	end

	// byte path
	always_ff @(posedge clk) begin
		if (take) buf_mem[fill[IDX_W-1:0]] <= tcp_din;
		tx_d <= (left != '0) ? buf_mem[rd_idx] : hdr;
	end

	assign phy_tx = '{d: tx_d, v: tx_v};

endmodule

// File: design/stream_defines.svh
`ifndef STREAM_DEFINES_SVH
`define STREAM_DEFINES_SVH

// largest payload of one data segment in bytes
// amount field is 6 bits wide so keep this below 64
`define STREAM_MAX_SEG 8

// data segment credits granted to each side at connection setup
`define STREAM_INIT_CREDITS 4

// cycles without answer before the SYN goes out again
`define STREAM_SYN_RETRY 200

`endif

// File: design/stream_endpoint.sv
`timescale 1ns/10ps

module stream_endpoint import stream_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  phy_t       phy_rx,
	output phy_t       phy_tx,
	input  logic [7:0] tcp_din,
	input  logic       tcp_vin,
	output logic       tcp_cts,
	output logic [7:0] tcp_dout,
	output logic       tcp_vout,
	input  logic       connect,
	output logic       connected,
	input  logic       listen
);

	ctl_req_t ctl_req;
	rx_evt_t  rx_evt;
	logic     ctl_sent;
	logic     retry_due;
	logic     timer_start;
	logic     timer_stop;

	//////////////////////////////////////////////////////////////////////
	// connection control
	//////////////////////////////////////////////////////////////////////

	conn_fsm conn_fsm_inst (
		.clk         (clk),
		.rst         (rst),
		.connect     (connect),
		.listen      (listen),
		.rx_evt      (rx_evt),
		.ctl_sent    (ctl_sent),
		.retry_due   (retry_due),
		.ctl_req     (ctl_req),
		.timer_start (timer_start),
		.timer_stop  (timer_stop),
		.connected   (connected)
	);

	// syn resend timing
	syn_timer syn_timer_inst (
		.clk       (clk),
		.rst       (rst),
		.start     (timer_start),
		.stop      (timer_stop),
		.retry_due (retry_due)
	);

	//////////////////////////////////////////////////////////////////////
	// segment datapath
	//////////////////////////////////////////////////////////////////////

	seg_tx seg_tx_inst (
		.clk       (clk),
		.rst       (rst),
		.connected (connected),
		.ctl_req   (ctl_req),
		.rx_evt    (rx_evt),
		.tcp_din   (tcp_din),
		.tcp_vin   (tcp_vin),
		.tcp_cts   (tcp_cts),
		.ctl_sent  (ctl_sent),
		.phy_tx    (phy_tx)
	);

	seg_rx seg_rx_inst (
		.clk      (clk),
		.rst      (rst),
		.phy_rx   (phy_rx),
		.rx_evt   (rx_evt),
		.tcp_dout (tcp_dout),
		.tcp_vout (tcp_vout)
	);

endmodule

// File: design/stream_pkg.sv
package stream_pkg;

	// one direction of the byte wide phy
	typedef struct packed {
		logic [7:0] d;
		logic       v;
	} phy_t;

	// segment kind sits in the top two bits of every header
	typedef enum logic [1:0] {
		kind_ctl = 2'd0,
		kind_dat = 2'd1,
		kind_crd = 2'd2
	} seg_kind_t;

	// control view of the header byte
	typedef struct packed {
		seg_kind_t  kind;
		logic       syn;
		logic       ack;
		logic [3:0] rsvd;
	} hdr_ctl_t;

	// data view, also used by credit segments
	typedef struct packed {
		seg_kind_t  kind;
		logic [5:0] amount;
	} hdr_dat_t;

	typedef union packed {
		hdr_ctl_t ctl;
		hdr_dat_t dat;
	} seg_hdr_u;

	// handshake request towards the transmitter
	typedef struct packed {
		logic valid;
		logic syn;
		logic ack;
	} ctl_req_t;

	// receiver events, all single cycle
	typedef struct packed {
		logic       syn_seen;
		logic       ack_seen;
		logic       crd_gain;
		logic [5:0] crd_amount;
		logic       seg_done;
	} rx_evt_t;

endpackage

// File: design/syn_timer.sv
`timescale 1ns/10ps

`include "stream_defines.svh"

module syn_timer (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic stop,
	output logic retry_due
);

	localparam int RETRY = `STREAM_SYN_RETRY;
	localparam int CNT_W = $clog2(RETRY);

	logic [CNT_W-1:0] count;
	logic             running;

	always_ff @(posedge clk) begin
		if (rst) begin
			count     <= '0;
			running   <= 1'b0;
			retry_due <= 1'b0;
		end
		else begin
			retry_due <= 1'b0;
			// stop wins over start, count held at zero
			if (stop) begin
				count   <= '0;
				running <= 1'b0;
			end
			else if (start) begin
				count   <= '0;
				running <= 1'b1;
			end
			else if (running) begin
				// wrap and keep running until told otherwise
				if (count == CNT_W'(RETRY - 1)) begin
					count     <= '0;
					retry_due <= 1'b1;
				end
				else count <= count + 1'b1;
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the two endpoint testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_stream \
	-f vlog.f -o sim_tb_stream || exit 1
./obj_dir/sim_tb_stream > sim.log 2>&1
cat sim.log
grep -q "Regression passed" sim.log && exit 0 || exit 1

// File: verif/tb_stream.sv
`timescale 1ns/10ps

`include "stream_defines.svh"

module tb_stream import stream_pkg::*; ();

	localparam int NUM_BYTES = 400;
	localparam int RETRY     = `STREAM_SYN_RETRY;
	localparam int MAX_SEG   = `STREAM_MAX_SEG;
	localparam int CREDITS   = `STREAM_INIT_CREDITS;
	// 400 bytes at worst case credit stalls plus 3 syn retries
	localparam int LIMIT     = 20000;

	logic       clk     = 1'b0;
	logic       rst     = 1'b1;
	logic       connect = 1'b0;
	logic       listen  = 1'b0;
	logic [7:0] c_din   = 8'h00;
	logic       c_vin   = 1'b0;
	logic [7:0] s_din   = 8'h00;
	logic       s_vin   = 1'b0;
	phy_t       c_tx;
	phy_t       s_tx;
	logic [7:0] c_dout;
	logic [7:0] s_dout;
	logic       c_cts;
	logic       s_cts;
	logic       c_vout;
	logic       s_vout;
	logic       c_conn;
	logic       s_conn;

	// expected bytes per direction
	logic [7:0] q_c2s [$];
	logic [7:0] q_s2c [$];

	int         cycle     = 0;
	int         c_acc     = 0;
	int         c_gap     = 0;
	int         c_rcvd    = 0;
	int         s_rcvd    = 0;
	int         syn_count = 0;
	int         last_syn  = 0;
	logic [7:0] s_count   = 8'h00;
	logic       stim_stop = 1'b0;

	// wire 0 is the client phy_tx, wire 1 the server phy_tx
	int seg_left [2] = '{0, 0};
	int dat_segs [2] = '{0, 0};
	int crd_back [2] = '{0, 0};

	always #4 clk = ~clk;

	stream_endpoint stream_endpoint_inst (
		.clk       (clk),
		.rst       (rst),
		.phy_rx    (s_tx),
		.phy_tx    (c_tx),
		.tcp_din   (c_din),
		.tcp_vin   (c_vin),
		.tcp_cts   (c_cts),
		.tcp_dout  (c_dout),
		.tcp_vout  (c_vout),
		.connect   (connect),
		.connected (c_conn),
		.listen    (1'b0)
	);

	// server side, wired the other way round
	stream_endpoint peer_inst (
		.clk       (clk),
		.rst       (rst),
		.phy_rx    (c_tx),
		.phy_tx    (s_tx),
		.tcp_din   (s_din),
		.tcp_vin   (s_vin),
		.tcp_cts   (s_cts),
		.tcp_dout  (s_dout),
		.tcp_vout  (s_vout),
		.connect   (1'b0),
		.connected (s_conn),
		.listen    (listen)
	);

	task automatic report_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	// mostly back to back bytes, now and then a pause that cuts a segment
	function automatic int pick_gap();
		if ($urandom_range(7, 0) == 0) return $urandom_range(6, 1);
		return 0;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// header walk on one wire, credit bookkeeping per direction
	//////////////////////////////////////////////////////////////////////

	task automatic parse_wire(input int d, input phy_t p);
		seg_hdr_u hdr;
		int       out;
		hdr = p.d;
		if (p.v && seg_left[d] > 0) begin
			seg_left[d] = seg_left[d] - 1;
		end
		else if (p.v) begin
			case (hdr.ctl.kind)
				kind_ctl : begin
					// pure syn from the client
					if (d == 0 && hdr.ctl.syn && !hdr.ctl.ack) begin
						if (syn_count > 0) begin
							assert (cycle - last_syn >= RETRY)
							else report_error($sformatf("SYN resent after %0d cycles",
								cycle - last_syn));
						end
						syn_count = syn_count + 1;
						last_syn  = cycle;
					end
				end
				kind_dat : begin
					assert (hdr.dat.amount != 0 && int'(hdr.dat.amount) <= MAX_SEG)
					else report_error($sformatf("wire %0d data segment of %0d bytes",
						d, hdr.dat.amount));
					seg_left[d] = int'(hdr.dat.amount);
					dat_segs[d] = dat_segs[d] + 1;
					out         = dat_segs[d] - crd_back[d];
					assert (out <= CREDITS)
					else report_error($sformatf("wire %0d has %0d segments in flight",
						d, out));
				end
				// credits coming back free the other direction
				kind_crd : crd_back[1 - d] = crd_back[1 - d] + int'(hdr.dat.amount);
				default  : report_error($sformatf("wire %0d unknown header %02h", d, p.d));
			endcase
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks, sampled on the rising edge
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		logic [7:0] want;
		if (rst) begin
			if (cycle > 0) begin
				assert (!c_tx.v && !s_tx.v) else report_error("phy_tx valid during reset");
			end
		end
		else begin
			assert (c_conn || (!c_cts && !c_vout))
			else report_error("client cts or vout high before connected");
			assert (s_conn || (!s_cts && !s_vout))
			else report_error("server cts or vout high before connected");
			parse_wire(0, c_tx);
			parse_wire(1, s_tx);
			if (s_vout) begin
				if (q_c2s.size() == 0) report_error("server delivered an unsent byte");
				else begin
					want = q_c2s.pop_front();
					assert (s_dout == want)
					else report_error($sformatf("server got %02h, expected %02h", s_dout, want));
					s_rcvd = s_rcvd + 1;
				end
			end
			if (c_vout) begin
				if (q_s2c.size() == 0) report_error("client delivered an unsent byte");
				else begin
					want = q_s2c.pop_front();
					assert (c_dout == want)
					else report_error($sformatf("client got %02h, expected %02h", c_dout, want));
					c_rcvd = c_rcvd + 1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus, both directions at once
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		int g;
		if (!rst) begin
			// client byte held until taken
			if (c_vin && c_cts) begin
				q_c2s.push_back(c_din);
				c_acc <= c_acc + 1;
				g = pick_gap();
				if (g == 0 && c_acc + 1 < NUM_BYTES) c_din <= 8'($urandom);
				else begin
					c_vin <= 1'b0;
					c_gap <= g;
				end
			end
			else if (!c_vin && c_acc < NUM_BYTES) begin
				if (c_gap > 0) c_gap <= c_gap - 1;
				else if (c_cts) begin
					c_vin <= 1'b1;
					c_din <= 8'($urandom);
				end
			end
			// server counter byte every 16 cycles
			if (s_vin && s_cts) begin
				q_s2c.push_back(s_din);
				s_vin   <= 1'b0;
				s_count <= s_count + 1'b1;
			end
			else if (!s_vin && !stim_stop && s_cts && cycle % 16 == 0) begin
				s_vin <= 1'b1;
				s_din <= s_count;
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			$display("timeout: run still going after %0d cycles", LIMIT);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		void'($urandom(21287));
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		connect <= 1'b1;
		// late listener forces syn retries
		repeat (3 * RETRY) @(posedge clk);
		listen <= 1'b1;
		while (!(c_conn && s_conn)) @(posedge clk);
		$display("connected at cycle %0d after %0d client SYNs", cycle, syn_count);
		while (!(c_acc == NUM_BYTES && q_c2s.size() == 0)) @(posedge clk);
		stim_stop <= 1'b1;
		@(posedge clk);
		while (s_vin || q_s2c.size() != 0) @(posedge clk);
		repeat (4) @(posedge clk);
		if (syn_count >= 2 && s_rcvd == NUM_BYTES && c_rcvd > 0) begin
			$display("Regression passed");
			$finish;
		end
		else report_error($sformatf("end of run with %0d SYNs, %0d and %0d bytes delivered",
			syn_count, s_rcvd, c_rcvd));
	end

endmodule

// File: vlog.f
+incdir+design
design/stream_pkg.sv
design/syn_timer.sv
design/conn_fsm.sv
design/seg_tx.sv
design/seg_rx.sv
design/stream_endpoint.sv
verif/tb_stream.sv
